//--- tb.f
hw/hbus_pkg.sv
hw/hbus_cycle_counter.sv
hw/hbus_fsm.sv
hw/hbus_ca_shifter.sv
hw/hbus_read_capture.sv
hw/hbus_ctrl.sv
testbench/hbus_clk_gen.sv
testbench/hbus_mem_model.sv
testbench/tb_hbus_ctrl.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_hbus_ctrl
RTL_TOP   ?= hbus_ctrl
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= ALL CHECKS PASSED
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- testbench/tb_hbus_ctrl.sv
// HyperBus controller testbench
// Runs a table of read, write and timeout transactions against a HyperRAM model

`timescale 1ns/1ps

module tb_hbus_ctrl;
    import hbus_pkg::*;

    localparam int TACC_COUNT     = 6;
    localparam int RESET_COUNT    = 4;
    localparam int ADDR_LENGTH    = 32;
    localparam int STROBE_TIMEOUT = 16;
    localparam int WAIT_LIMIT     = 200;
    localparam int NUM_ENTRIES    = 7;

    typedef struct {
        logic        is_write;
        logic        reg_space;
        logic [31:0] addr;
        int          count;
        logic [15:0] first;
        logic        mute;
    } entry_t;

    logic        clk;
    logic        rst;
    logic [31:0] adr_i;
    logic [15:0] dat_i;
    logic        reg_space_i;
    logic        rrq_i;
    logic        wrq_i;
    logic [15:0] dat_o;
    logic        ready_o;
    logic        valid_o;
    logic        busy_o;
    logic        error_o;
    logic        hbus_csn_o;
    logic        hbus_rstn_o;
    logic        hbus_ck_en_o;
    logic [15:0] hbus_dq_o;
    logic        hbus_dq_oe_o;
    logic [1:0]  hbus_rwds_o;
    logic        hbus_rwds_oe_o;
    logic [15:0] hbus_dq_i;
    logic [1:0]  hbus_rwds_i;
    logic        mute_strobe;
    logic        cmd_rw;
    logic        cmd_reg;
    logic [31:0] cmd_addr;

    int     mismatch_cnt = 0;
    int     fail_cnt     = 0;
    int     recovery_err = 0;
    int     high_run     = 0;
    entry_t entries [NUM_ENTRIES];

    hbus_clk_gen #(.PERIOD_NS(4), .RESET_CYCLES(5)) hbus_clk_gen_inst (
        .clk_o (clk),
        .rst_o (rst)
    );

    hbus_ctrl #(
        .TACC_COUNT     (TACC_COUNT),
        .RESET_COUNT    (RESET_COUNT),
        .ADDR_LENGTH    (ADDR_LENGTH),
        .STROBE_TIMEOUT (STROBE_TIMEOUT)
    ) hbus_ctrl_inst (
        .clk            (clk),
        .rst            (rst),
        .adr_i          (adr_i),
        .dat_i          (dat_i),
        .reg_space_i    (reg_space_i),
        .rrq_i          (rrq_i),
        .wrq_i          (wrq_i),
        .dat_o          (dat_o),
        .ready_o        (ready_o),
        .valid_o        (valid_o),
        .busy_o         (busy_o),
        .error_o        (error_o),
        .hbus_csn_o     (hbus_csn_o),
        .hbus_rstn_o    (hbus_rstn_o),
        .hbus_ck_en_o   (hbus_ck_en_o),
        .hbus_dq_o      (hbus_dq_o),
        .hbus_dq_oe_o   (hbus_dq_oe_o),
        .hbus_rwds_o    (hbus_rwds_o),
        .hbus_rwds_oe_o (hbus_rwds_oe_o),
        .hbus_dq_i      (hbus_dq_i),
        .hbus_rwds_i    (hbus_rwds_i)
    );

    hbus_mem_model #(.TACC_COUNT(TACC_COUNT)) mem_model_inst (
        .clk        (clk),
        .csn_i      (hbus_csn_o),
        .dq_oe_i    (hbus_dq_oe_o),
        .dq_i       (hbus_dq_o),
        .mute_i     (mute_strobe),
        .dq_o       (hbus_dq_i),
        .rwds_o     (hbus_rwds_i),
        .cmd_rw_o   (cmd_rw),
        .cmd_reg_o  (cmd_reg),
        .cmd_addr_o (cmd_addr)
    );

    // One cycle after the request drops plus one recovery cycle
    always @(negedge clk) begin
        if (hbus_csn_o) begin
            high_run <= high_run + 1;
        end else begin
            if (high_run != 0) begin
                assert (high_run >= 2) else begin
                    recovery_err++;
                    $display("Chip select high for only %0d cycle(s) at %0t", high_run, $time);
                end
            end
            high_run <= 0;
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            mismatch_cnt++;
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic report_failure(input string what);
        fail_cnt++;
        $display("At %0t: %s", $time, what);
    endtask

    task automatic check_command(input entry_t e);
        check_value("cmd rw flag", cmd_rw, !e.is_write);
        check_value("cmd space flag", cmd_reg, e.reg_space);
        check_value("cmd address", cmd_addr, e.addr);
    endtask

    // Drives a request on the rising edge the caller is aligned to
    task automatic start_request(input entry_t e);
        adr_i       <= e.addr;
        reg_space_i <= e.reg_space;
        dat_i       <= e.first;
        mute_strobe <= e.mute;
        wrq_i       <= e.is_write;
        rrq_i       <= !e.is_write;
    endtask

    // Chip select back high and, after a write, the stored burst
    task automatic check_finished(input entry_t e);
        logic [7:0] idx;
        #1;
        check_value("hbus_csn_o", hbus_csn_o, 1);
        if (e.is_write) begin
            for (int i = 0; i < e.count; i++) begin
                idx = e.addr[7:0] + 8'(i);
                check_value("stored word", mem_model_inst.mem[idx], e.first + 16'(i));
            end
        end
    endtask

    task automatic wait_select();
        int n;
        n = 0;
        do begin
            @(posedge clk);
            #1;
            n++;
        end while (hbus_csn_o && n < WAIT_LIMIT);
        assert (!hbus_csn_o) else report_failure("timed out waiting for chip select");
    endtask

    task automatic check_reset();
        int n;
        n = 0;
        do begin
            @(posedge clk);
            #1;
            n++;
        end while (rst && n < WAIT_LIMIT);
        check_value("hbus_csn_o", hbus_csn_o, 1);
        check_value("hbus_dq_oe_o", hbus_dq_oe_o, 0);
        check_value("hbus_rwds_oe_o", hbus_rwds_oe_o, 0);
        check_value("hbus_ck_en_o", hbus_ck_en_o, 0);
        check_value("ready_o", ready_o, 0);
        check_value("valid_o", valid_o, 0);
        check_value("error_o", error_o, 0);
        check_value("busy_o", busy_o, 1);
        n = 0;
        do begin
            @(posedge clk);
            #1;
            n++;
            if (!hbus_rstn_o) begin
                check_value("hbus_csn_o", hbus_csn_o, 1);
                check_value("busy_o", busy_o, 1);
            end
        end while (busy_o && n < WAIT_LIMIT);
        check_value("busy_o fall cycle", n, RESET_COUNT + 1);
        check_value("hbus_rstn_o", hbus_rstn_o, 1);
    endtask

    task automatic run_write(input entry_t e);
        int lat;
        wait_select();
        // Load cycle already counted
        lat = 1;
        do begin
            @(posedge clk);
            #1;
            lat++;
        end while (!ready_o && lat < WAIT_LIMIT);
        check_value("ready_o latency", lat, 4 + (e.addr[3] ? 2 : 1) * TACC_COUNT);
        check_command(e);
        for (int i = 1; i < e.count; i++) begin
            @(posedge clk);
            dat_i <= e.first + 16'(i);
            if (i == e.count - 1) begin
                wrq_i <= 1'b0;
            end
            #1;
            check_value("ready_o", ready_o, 1);
            check_value("hbus_rwds_o", hbus_rwds_o, 2'b00);
            check_value("hbus_rwds_oe_o", hbus_rwds_oe_o, 1);
        end
        // Controller sees the drop on this edge
        @(posedge clk);
    endtask

    task automatic run_read(input entry_t e);
        int k;
        int n;
        wait_select();
        k = 0;
        n = 0;
        while (k < e.count && n < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            n++;
            if (valid_o) begin
                check_value("dat_o", dat_o, 16'(e.addr + 32'(k)));
                k++;
            end
        end
        assert (k == e.count) else report_failure("read burst timed out with words missing");
        check_command(e);
        @(posedge clk);
        rrq_i <= 1'b0;
        @(posedge clk);
    endtask

    task automatic run_timeout(input entry_t e);
        int n;
        int limit;
        wait_select();
        limit = 3 + (e.addr[3] ? 2 : 1) * TACC_COUNT + STROBE_TIMEOUT + 1;
        n = 0;
        do begin
            @(posedge clk);
            #1;
            n++;
        end while (!error_o && n < WAIT_LIMIT);
        assert (error_o && n <= limit) else report_failure("error_o did not rise in time");
        repeat (4) begin
            @(posedge clk);
            #1;
            check_value("error_o", error_o, 1);
            check_value("hbus_csn_o", hbus_csn_o, 1);
        end
        @(posedge clk);
        rrq_i       <= 1'b0;
        mute_strobe <= 1'b0;
    endtask

    initial begin
        adr_i       = '0;
        dat_i       = '0;
        reg_space_i = 1'b0;
        rrq_i       = 1'b0;
        wrq_i       = 1'b0;
        mute_strobe = 1'b0;

        // write, space, address, words, first data, no strobes
        entries[0] = '{1'b1, 1'b0, 32'h0000_0010, 4, 16'h1200, 1'b0};
        entries[1] = '{1'b0, 1'b0, 32'h0000_0010, 4, 16'h0000, 1'b0};
        entries[2] = '{1'b1, 1'b0, 32'h0000_0028, 3, 16'ha5a0, 1'b0};
        entries[3] = '{1'b0, 1'b0, 32'h0000_0048, 6, 16'h0000, 1'b0};
        entries[4] = '{1'b1, 1'b1, 32'h0000_0001, 2, 16'h0f00, 1'b0};
        entries[5] = '{1'b0, 1'b0, 32'h1fff_fff0, 5, 16'h0000, 1'b0};
        entries[6] = '{1'b0, 1'b0, 32'h0000_0100, 1, 16'h0000, 1'b1};

        check_reset();
        @(posedge clk);
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            // Next request goes out on the edge where the previous one ended
            start_request(entries[i]);
            if (i > 0) begin
                check_finished(entries[i - 1]);
            end
            if (entries[i].mute) begin
                run_timeout(entries[i]);
            end else if (entries[i].is_write) begin
                run_write(entries[i]);
            end else begin
                run_read(entries[i]);
            end
        end
        check_finished(entries[NUM_ENTRIES - 1]);
        repeat (2) @(posedge clk);

        $display("Summary: %0d mismatches, %0d other failures, %0d recovery errors",
                 mismatch_cnt, fail_cnt, recovery_err);
        if (mismatch_cnt + fail_cnt + recovery_err == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- testbench/hbus_mem_model.sv
// Behavioural HyperRAM model
// Decodes CA beats, stores write words and returns reads with random strobe gaps

`timescale 1ns/1ps

module hbus_mem_model #(
    parameter int TACC_COUNT = 6
) (
    input  logic        clk,
    input  logic        csn_i,
    input  logic        dq_oe_i,
    input  logic [15:0] dq_i,
    input  logic        mute_i,
    output logic [15:0] dq_o,
    output logic [1:0]  rwds_o,
    output logic        cmd_rw_o,
    output logic        cmd_reg_o,
    output logic [31:0] cmd_addr_o
);
    import hbus_pkg::*;

    logic [15:0] mem [0:255];
    ca_word_u    ca_q;
    int          beat_q;
    int          wait_q;
    int          word_q;
    int          gap_q;
    logic        active_q;
    logic [31:0] lcg_q;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        lcg_next = s * 32'd1664525 + 32'd1013904223;
    endfunction

    assign cmd_rw_o   = ca_q.field.rw;
    assign cmd_reg_o  = ca_q.field.reg_space;
    assign cmd_addr_o = {ca_q.field.addr_hi, ca_q.field.addr_lo};

    initial begin
        ca_q     = '0;
        beat_q   = 0;
        wait_q   = 0;
        word_q   = 0;
        gap_q    = 0;
        active_q = 1'b0;
        lcg_q    = 32'hf6660c98;
        dq_o     = '0;
        rwds_o   = 2'b00;
    end

    always @(posedge clk) begin
        if (csn_i) begin
            beat_q   <= 0;
            wait_q   <= 0;
            word_q   <= 0;
            gap_q    <= 0;
            active_q <= 1'b0;
            rwds_o   <= 2'b00;
        end else if (beat_q < 3) begin
            ca_q.beat <= {ca_q.beat[1:0], dq_i};
            beat_q    <= beat_q + 1;
            if (beat_q == 1) begin
                // Bit 0 of the second beat is address bit 3, which asks for 2x latency
                rwds_o <= dq_i[0] ? 2'b11 : 2'b00;
            end else if (beat_q == 2) begin
                rwds_o <= 2'b00;
                wait_q <= ca_q.beat[0][0] ? 2 * TACC_COUNT : TACC_COUNT;
            end
        end else if (!ca_q.field.rw) begin
            if (dq_oe_i) begin
                mem[cmd_addr_o[7:0] + word_q[7:0]] <= dq_i;
                word_q <= word_q + 1;
            end
        end else if (!active_q && wait_q > 1) begin
            wait_q <= wait_q - 1;
        end else begin
            active_q <= 1'b1;
            lcg_q    <= lcg_next(lcg_q);
            // Gaps are capped at three in a row
            if (mute_i || (lcg_q[17:16] == 2'b00 && gap_q < 3)) begin
                rwds_o <= 2'b00;
                gap_q  <= gap_q + 1;
            end else begin
                rwds_o <= 2'b10;
                dq_o   <= 16'(cmd_addr_o + 32'(word_q));
                word_q <= word_q + 1;
                gap_q  <= 0;
            end
        end
    end

endmodule

//--- testbench/hbus_clk_gen.sv
// Testbench clock and reset generator
// Free-running clock, reset held high for a fixed number of cycles

`timescale 1ns/1ps

module hbus_clk_gen #(
    parameter int PERIOD_NS    = 4,
    parameter int RESET_CYCLES = 5
) (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
    end

    initial begin
        rst_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        rst_o <= 1'b0;
    end

endmodule

//--- hw/hbus_ctrl.sv
// HyperBus primary controller top level
// Connects FSM, interval counter, CA shifter and read capture

`timescale 1ns/1ps

module hbus_ctrl #(
    parameter int TACC_COUNT     = 6,
    parameter int RESET_COUNT    = 4,
    parameter int ADDR_LENGTH    = 32,
    parameter int STROBE_TIMEOUT = 16
) (
    input  logic                             clk,
    input  logic                             rst,
    // Requester side
    input  logic [ADDR_LENGTH-1:0]           adr_i,
    input  logic [hbus_pkg::HBUS_WORD_W-1:0] dat_i,
    input  logic                             reg_space_i,
    input  logic                             rrq_i,
    input  logic                             wrq_i,
    output logic [hbus_pkg::HBUS_WORD_W-1:0] dat_o,
    output logic                             ready_o,
    output logic                             valid_o,
    output logic                             busy_o,
    output logic                             error_o,
    // Device side, both DDR beats per clk
    output logic                             hbus_csn_o,
    output logic                             hbus_rstn_o,
    output logic                             hbus_ck_en_o,
    output logic [hbus_pkg::HBUS_WORD_W-1:0] hbus_dq_o,
    output logic                             hbus_dq_oe_o,
    output logic [1:0]                       hbus_rwds_o,
    output logic                             hbus_rwds_oe_o,
    input  logic [hbus_pkg::HBUS_WORD_W-1:0] hbus_dq_i,
    input  logic [1:0]                       hbus_rwds_i
);
    import hbus_pkg::*;

    logic      cnt_load;
    cnt_load_e cnt_sel;
    logic      cnt_zero;
    logic      ca_load;
    logic      ca_shift;
    logic      send_data;
    logic      reading;
    logic      strobe_seen;

    // No byte masking, every written byte is kept
    assign hbus_rwds_o = 2'b00;

    hbus_fsm hbus_fsm_inst (
        .clk           (clk),
        .rst           (rst),
        .rrq_i         (rrq_i),
        .wrq_i         (wrq_i),
        .cnt_zero_i    (cnt_zero),
        .rwds_lat_i    (hbus_rwds_i),
        .strobe_seen_i (strobe_seen),
        .cnt_load_o    (cnt_load),
        .cnt_sel_o     (cnt_sel),
        .ca_load_o     (ca_load),
        .ca_shift_o    (ca_shift),
        .send_data_o   (send_data),
        .reading_o     (reading),
        .csn_o         (hbus_csn_o),
        .rstn_o        (hbus_rstn_o),
        .ck_en_o       (hbus_ck_en_o),
        .dq_oe_o       (hbus_dq_oe_o),
        .rwds_oe_o     (hbus_rwds_oe_o),
        .ready_o       (ready_o),
        .busy_o        (busy_o),
        .error_o       (error_o)
    );

    hbus_cycle_counter #(
        .TACC_COUNT     (TACC_COUNT),
        .RESET_COUNT    (RESET_COUNT),
        .STROBE_TIMEOUT (STROBE_TIMEOUT)
    ) hbus_cycle_counter_inst (
        .clk    (clk),
        .rst    (rst),
        .load_i (cnt_load),
        .sel_i  (cnt_sel),
        .zero_o (cnt_zero)
    );

    hbus_ca_shifter #(
        .ADDR_LENGTH (ADDR_LENGTH)
    ) hbus_ca_shifter_inst (
        .clk         (clk),
        .rst         (rst),
        .load_i      (ca_load),
        .shift_i     (ca_shift),
        .send_data_i (send_data),
        .rrq_i       (rrq_i),
        .reg_space_i (reg_space_i),
        .adr_i       (adr_i),
        .dat_i       (dat_i),
        .dq_o        (hbus_dq_o)
    );

    hbus_read_capture hbus_read_capture_inst (
        .clk           (clk),
        .rst           (rst),
        .reading_i     (reading),
        .dq_i          (hbus_dq_i),
        .rwds_i        (hbus_rwds_i),
        .dat_o         (dat_o),
        .valid_o       (valid_o),
        .strobe_seen_o (strobe_seen)
    );

endmodule

//--- hw/hbus_read_capture.sv
// HyperBus read capture
// Registers DQ on each RWDS strobe pair and pulses valid

`timescale 1ns/1ps

module hbus_read_capture (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             reading_i,
    input  logic [hbus_pkg::HBUS_WORD_W-1:0] dq_i,
    input  logic [1:0]                       rwds_i,
    output logic [hbus_pkg::HBUS_WORD_W-1:0] dat_o,
    output logic                             valid_o,
    output logic                             strobe_seen_o
);
    logic strobe;

    // Rising then falling RWDS within one clk marks a full word
    assign strobe        = reading_i && (rwds_i == 2'b10);
    assign strobe_seen_o = strobe;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= strobe;
        end
    end

    always_ff @(posedge clk) begin
        if (strobe) begin
            dat_o <= dq_i;
        end
    end

    // A 01 pair means the device strobe is half a clk out of phase
    a_rwds_aligned: assert property (@(posedge clk) disable iff (rst)
        reading_i |-> (rwds_i != 2'b01));

endmodule

//--- hw/hbus_ca_shifter.sv
// HyperBus command/address shifter
// Builds the CA word and drives its beats, or write data, onto DQ

`timescale 1ns/1ps

module hbus_ca_shifter #(
    parameter int ADDR_LENGTH = 32
) (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             load_i,
    input  logic                             shift_i,
    input  logic                             send_data_i,
    input  logic                             rrq_i,
    input  logic                             reg_space_i,
    input  logic [ADDR_LENGTH-1:0]           adr_i,
    input  logic [hbus_pkg::HBUS_WORD_W-1:0] dat_i,
    output logic [hbus_pkg::HBUS_WORD_W-1:0] dq_o
);
    import hbus_pkg::*;

    ca_word_u ca_q;
    ca_word_u ca_d;

    always_comb begin
        ca_d                 = '0;
        ca_d.field.rw        = rrq_i;
        ca_d.field.reg_space = reg_space_i;
        // Only linear bursts are issued
        ca_d.field.linear    = 1'b1;
        ca_d.field.addr_hi   = 29'(adr_i >> 3);
        ca_d.field.addr_lo   = adr_i[2:0];
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ca_q <= '0;
        end else if (load_i) begin
            ca_q <= ca_d;
        end else if (shift_i) begin
            ca_q.beat <= {ca_q.beat[1:0], {HBUS_WORD_W{1'b0}}};
        end
    end

    // Top beat is the one on the bus this cycle
    assign dq_o = send_data_i ? dat_i : ca_q.beat[2];

endmodule

//--- hw/hbus_fsm.sv
// HyperBus transaction FSM
// Sequences reset, command, latency and data phases and drives the bus controls

`timescale 1ns/1ps

module hbus_fsm (
    input  logic                clk,
    input  logic                rst,
    input  logic                rrq_i,
    input  logic                wrq_i,
    input  logic                cnt_zero_i,
    input  logic [1:0]          rwds_lat_i,
    input  logic                strobe_seen_i,
    output logic                cnt_load_o,
    output hbus_pkg::cnt_load_e cnt_sel_o,
    output logic                ca_load_o,
    output logic                ca_shift_o,
    output logic                send_data_o,
    output logic                reading_o,
    output logic                csn_o,
    output logic                rstn_o,
    output logic                ck_en_o,
    output logic                dq_oe_o,
    output logic                rwds_oe_o,
    output logic                ready_o,
    output logic                busy_o,
    output logic                error_o
);
    import hbus_pkg::*;

    // One-hot state bit positions
    localparam int NUM_ST   = 7;
    localparam int ST_RESET = 0;
    localparam int ST_IDLE  = 1;
    localparam int ST_CMD   = 2;
    localparam int ST_LAT   = 3;
    localparam int ST_READ  = 4;
    localparam int ST_WRITE = 5;
    localparam int ST_ERROR = 6;

    logic [NUM_ST-1:0] state_q;
    logic [NUM_ST-1:0] state_d;
    logic              on_bus_d;

    function automatic logic [NUM_ST-1:0] st(input int idx);
        st = '0;
        st[idx] = 1'b1;
    endfunction

    always_comb begin
        state_d    = state_q;
        cnt_load_o = 1'b0;
        cnt_sel_o  = CNT_RESET;
        ca_load_o  = 1'b0;
        case (1'b1)
            state_q[ST_RESET]: begin
                if (cnt_zero_i) begin
                    state_d = st(ST_IDLE);
                end
            end
            state_q[ST_IDLE]: begin
                // Zero count here also means the recovery cycle has passed
                if (cnt_zero_i && (rrq_i || wrq_i)) begin
                    ca_load_o  = 1'b1;
                    cnt_load_o = 1'b1;
                    cnt_sel_o  = CNT_CMD;
                    state_d    = st(ST_CMD);
                end
            end
            state_q[ST_CMD]: begin
                if (cnt_zero_i) begin
                    // Device asks for double latency with RWDS high during CA
                    cnt_load_o = 1'b1;
                    cnt_sel_o  = (rwds_lat_i == 2'b11) ? CNT_LAT2 : CNT_LAT1;
                    state_d    = st(ST_LAT);
                end
            end
            state_q[ST_LAT]: begin
                if (cnt_zero_i) begin
                    cnt_load_o = 1'b1;
                    cnt_sel_o  = CNT_TIMEOUT;
                    state_d    = rrq_i ? st(ST_READ) : st(ST_WRITE);
                end
            end
            state_q[ST_READ]: begin
                if (!rrq_i) begin
                    cnt_load_o = 1'b1;
                    cnt_sel_o  = CNT_RECOVERY;
                    state_d    = st(ST_IDLE);
                end else if (strobe_seen_i) begin
                    cnt_load_o = 1'b1;
                    cnt_sel_o  = CNT_TIMEOUT;
                end else if (cnt_zero_i) begin
                    state_d = st(ST_ERROR);
                end
            end
            state_q[ST_WRITE]: begin
                // dat_i is taken on every ready cycle, the one where wrq_i drops too
                if (!wrq_i) begin
                    cnt_load_o = 1'b1;
                    cnt_sel_o  = CNT_RECOVERY;
                    state_d    = st(ST_IDLE);
                end
            end
            state_q[ST_ERROR]: begin
                state_d = state_q;
            end
            default: begin
                state_d = st(ST_RESET);
            end
        endcase
    end

    assign on_bus_d = state_d[ST_CMD] | state_d[ST_LAT] | state_d[ST_READ] | state_d[ST_WRITE];

    // Bus controls follow the next state so they change with the state register
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q   <= st(ST_RESET);
            csn_o     <= 1'b1;
            rstn_o    <= 1'b0;
            ck_en_o   <= 1'b0;
            dq_oe_o   <= 1'b0;
            rwds_oe_o <= 1'b0;
            ready_o   <= 1'b0;
            busy_o    <= 1'b1;
            error_o   <= 1'b0;
        end else begin
            state_q   <= state_d;
            csn_o     <= ~on_bus_d;
            rstn_o    <= ~state_d[ST_RESET];
            ck_en_o   <= on_bus_d;
            dq_oe_o   <= state_d[ST_CMD] | state_d[ST_WRITE];
            rwds_oe_o <= state_d[ST_WRITE];
            ready_o   <= state_d[ST_WRITE];
            busy_o    <= ~state_d[ST_IDLE];
            error_o   <= state_d[ST_ERROR];
        end
    end

    assign ca_shift_o  = state_q[ST_CMD];
    assign send_data_o = state_q[ST_WRITE];
    assign reading_o   = state_q[ST_READ] & rrq_i;

    // Device is never selected while held in reset
    a_csn_rstn: assert property (@(posedge clk) disable iff (rst) !csn_o |-> rstn_o);

endmodule

//--- hw/hbus_cycle_counter.sv
// HyperBus interval counter
// Loads a named interval and counts down to zero, then holds

`timescale 1ns/1ps

module hbus_cycle_counter #(
    parameter int TACC_COUNT     = 6,
    parameter int RESET_COUNT    = 4,
    parameter int STROBE_TIMEOUT = 16
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                load_i,
    input  hbus_pkg::cnt_load_e sel_i,
    output logic                zero_o
);
    import hbus_pkg::*;

    // Loaded values are one less than the interval, zero marks its last cycle
    localparam int CMD_VAL  = 2;
    localparam int LAT1_VAL = TACC_COUNT - 1;
    localparam int LAT2_VAL = 2 * TACC_COUNT - 1;
    localparam int REC_VAL  = 1;
    localparam int TMO_VAL  = STROBE_TIMEOUT - 1;

    localparam int MAX_A   = (RESET_COUNT > LAT2_VAL) ? RESET_COUNT : LAT2_VAL;
    localparam int MAX_B   = (MAX_A > TMO_VAL) ? MAX_A : TMO_VAL;
    localparam int MAX_VAL = (MAX_B > CMD_VAL) ? MAX_B : CMD_VAL;
    localparam int CNT_W   = $clog2(MAX_VAL + 1);

    logic [CNT_W-1:0] count_q;

    function automatic logic [CNT_W-1:0] interval(input cnt_load_e sel);
        case (sel)
            CNT_RESET:    interval = CNT_W'(RESET_COUNT);
            CNT_CMD:      interval = CNT_W'(CMD_VAL);
            CNT_LAT1:     interval = CNT_W'(LAT1_VAL);
            CNT_LAT2:     interval = CNT_W'(LAT2_VAL);
            CNT_RECOVERY: interval = CNT_W'(REC_VAL);
            default:      interval = CNT_W'(TMO_VAL);
        endcase
    endfunction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            // Device reset interval starts as soon as rst is released
            count_q <= interval(CNT_RESET);
        end else if (load_i) begin
            count_q <= interval(sel_i);
        end else if (count_q != '0) begin
            count_q <= count_q - 1'b1;
        end
    end

    assign zero_o = (count_q == '0);

    // Latency must start from the last command cycle, never mid-interval
    a_lat_load_idle: assert property (@(posedge clk) disable iff (rst)
        (load_i && (sel_i inside {CNT_LAT1, CNT_LAT2})) |-> zero_o);

endmodule

//--- hw/hbus_pkg.sv
// HyperBus controller shared definitions
// Bus widths, command/address word layout and counter interval names

package hbus_pkg;

    // One DDR beat on DQ, two beats per clk cycle
    localparam int HBUS_DQ_W   = 8;
    localparam int HBUS_WORD_W = 2 * HBUS_DQ_W;
    localparam int HBUS_CA_W   = 3 * HBUS_WORD_W;

    // Command/address word, seen either as fields or as the three bus beats
    typedef union packed {
        struct packed {
            logic        rw;
            logic        reg_space;
            logic        linear;
            logic [28:0] addr_hi;
            logic [12:0] reserved;
            logic [2:0]  addr_lo;
        } field;
        // beat[2] goes out first
        logic [2:0][HBUS_WORD_W-1:0] beat;
    } ca_word_u;

    // Interval the cycle counter loads
    typedef enum logic [2:0] {
        CNT_RESET,
        CNT_CMD,
        CNT_LAT1,
        CNT_LAT2,
        CNT_RECOVERY,
        CNT_TIMEOUT
    } cnt_load_e;

endpackage
